// File: Bender.yml
package:
  name: axis_upsizer

sources:
  - hdl/axis_dw_pkg.sv
  - hdl/axis_skid_buffer.sv
  - hdl/lane_fill_fsm.sv
  - hdl/lane_pack_datapath.sv
  - hdl/axis_upsizer_top.sv
  - target: simulation
    files:
      - dv/axis_upsizer_checker.sv
      - dv/axis_upsizer_tb.sv

// File: build.f
hdl/axis_dw_pkg.sv
hdl/axis_skid_buffer.sv
hdl/lane_fill_fsm.sv
hdl/lane_pack_datapath.sv
hdl/axis_upsizer_top.sv
dv/axis_upsizer_checker.sv
dv/axis_upsizer_tb.sv

// File: dv/axis_upsizer_checker.sv
`timescale 1ns/1ps
`default_nettype none

module axis_upsizer_checker
  import axis_dw_pkg::*;
(
  input  wire                     aclk,
  input  wire                     arst_n,
  input  wire                     m_axis_tvalid,
  input  wire                     m_axis_tready,
  input  wire [m_bytes-1:0][7:0]  m_axis_tdata,
  input  wire [m_bytes-1:0]       m_axis_tkeep,
  input  wire [user_width-1:0]    m_axis_tuser,
  input  wire                     m_axis_tlast,
  // internal fsm view
  input  wire fill_state_t        fsm_state,
  // output skid accepting words
  input  wire                     word_ready
);

  // stalled word keeps its payload
  a_payload_stable: assert property (
    @(posedge aclk) disable iff (!arst_n)
    (m_axis_tvalid && !m_axis_tready) |=>
      ($stable(m_axis_tdata) && $stable(m_axis_tkeep) &&
       $stable(m_axis_tuser) && $stable(m_axis_tlast))
  ) else $error("m_axis payload changed while valid high and ready low");

  // valid only falls after a transfer
  a_valid_held: assert property (
    @(posedge aclk) disable iff (!arst_n)
    (m_axis_tvalid && !m_axis_tready) |=> m_axis_tvalid
  ) else $error("m_axis_tvalid dropped without a transfer");

  // fsm held in hold_full means the output skid is full
  // so a word must be showing on the pins
  a_full_offered: assert property (
    @(posedge aclk) disable iff (!arst_n)
    (fsm_state == hold_full && !word_ready) |-> m_axis_tvalid
  ) else $error("fsm held in hold_full with output skid valid low");

endmodule

bind axis_upsizer_top axis_upsizer_checker u_checker (
  .aclk          (aclk),
  .arst_n        (arst_n),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tready (m_axis_tready),
  .m_axis_tdata  (m_axis_tdata),
  .m_axis_tkeep  (m_axis_tkeep),
  .m_axis_tuser  (m_axis_tuser),
  .m_axis_tlast  (m_axis_tlast),
  .fsm_state     (u_fsm.state),
  .word_ready    (word_ready)
);

`default_nettype wire

// File: dv/axis_upsizer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axis_upsizer_tb
  import axis_dw_pkg::*;
();

  localparam int timeout_cycles = 2000;

  logic                     aclk;
  logic                     arst_n;
  logic                     s_axis_tvalid;
  logic                     s_axis_tready;
  logic [s_bytes-1:0][7:0]  s_axis_tdata;
  logic [s_bytes-1:0]       s_axis_tkeep;
  logic [user_width-1:0]    s_axis_tuser;
  logic                     s_axis_tlast;
  logic                     m_axis_tvalid;
  logic                     m_axis_tready;
  logic [m_bytes-1:0][7:0]  m_axis_tdata;
  logic [m_bytes-1:0]       m_axis_tkeep;
  logic [user_width-1:0]    m_axis_tuser;
  logic                     m_axis_tlast;

  logic [31:0] lcg_state;
  // beats still to send, words still expected
  in_beat_t    stim_q[$];
  out_beat_t   model_q[$];
  // model's half-filled word
  in_beat_t    pend_beat;
  logic        pend_valid;
  int          word_errors;
  int          flag_errors;
  int          other_errors;

  axis_upsizer_top axis_upsizer_top_inst (.*);

  initial aclk = 1'b0;
  always #50 aclk = ~aclk;

  // upper half of the lcg state, low bits are weak
  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {16'h0, lcg_state[31:16]};
  endfunction

  // packing rules: first beat low, second beat high, early last closes
  task automatic model_accept(input in_beat_t b);
    out_beat_t w;
    w = '0;
    if (!pend_valid && b.last) begin
      w.data[s_bytes-1:0] = b.data;
      w.keep[s_bytes-1:0] = b.keep;
      w.user = b.user;
      w.last = 1'b1;
      model_q.push_back(w);
    end else if (!pend_valid) begin
      pend_beat  = b;
      pend_valid = 1'b1;
    end else begin
      w.data = {b.data, pend_beat.data};
      w.keep = {b.keep, pend_beat.keep};
      w.user = pend_beat.user;
      w.last = b.last;
      model_q.push_back(w);
      pend_valid = 1'b0;
    end
  endtask

  task automatic check_word(input out_beat_t exp, input out_beat_t act);
    if (act.data !== exp.data) begin
      $display("ERROR t=%0t m_axis_tdata expected=%h actual=%h", $time, exp.data, act.data);
      word_errors++;
    end
    if (act.keep !== exp.keep) begin
      $display("ERROR t=%0t m_axis_tkeep expected=%b actual=%b", $time, exp.keep, act.keep);
      word_errors++;
    end
    if (act.user !== exp.user) begin
      $display("ERROR t=%0t m_axis_tuser expected=%h actual=%h", $time, exp.user, act.user);
      word_errors++;
    end
    if (act.last !== exp.last) begin
      $display("ERROR t=%0t m_axis_tlast expected=%b actual=%b", $time, exp.last, act.last);
      word_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR t=%0t %s expected=%b actual=%b", $time, name, exp, act);
      flag_errors++;
    end
  endtask

  // len_mode 0 even, 1 odd, 2 any
  task automatic build_packets(input int n_pkts, input int len_mode, input bit partial);
    int       len;
    in_beat_t b;
    for (int p = 0; p < n_pkts; p++) begin
      len = 1 + rand_next() % 6;
      if (len_mode == 0 && len % 2 == 1) begin
        len++;
      end
      if (len_mode == 1 && len % 2 == 0) begin
        len--;
      end
      for (int i = 0; i < len; i++) begin
        for (int k = 0; k < s_bytes; k++) begin
          b.data[k] = 8'(rand_next());
        end
        b.user = user_width'(rand_next());
        b.last = (i == len - 1);
        b.keep = '1;
        // contiguous partial keep, last beat only
        if (b.last && partial && rand_next() % 2 == 1) begin
          b.keep = s_bytes'((32'd1 << (1 + rand_next() % s_bytes)) - 1);
        end
        stim_q.push_back(b);
      end
    end
  endtask

  // runs until every beat is sent and every word seen, or until idle too long
  task automatic run_traffic(input int stall_pct, input int gap_pct);
    int        idle;
    bit        holding;
    bit        in_fire;
    bit        out_fire;
    out_beat_t act;
    idle    = 0;
    holding = 1'b0;
    while ((stim_q.size() != 0 || model_q.size() != 0) && idle < timeout_cycles) begin
      @(negedge aclk);
      if (!holding && stim_q.size() != 0 && rand_next() % 100 >= gap_pct) begin
        {s_axis_tdata, s_axis_tkeep, s_axis_tuser, s_axis_tlast} = stim_q[0];
        s_axis_tvalid = 1'b1;
        holding       = 1'b1;
      end else if (!holding) begin
        s_axis_tvalid = 1'b0;
      end
      m_axis_tready = (rand_next() % 100 >= stall_pct);
      // dut outputs are registered, they hold until the next rising edge
      in_fire  = s_axis_tvalid && s_axis_tready;
      out_fire = m_axis_tvalid && m_axis_tready;
      act      = out_beat_t'({m_axis_tdata, m_axis_tkeep, m_axis_tuser, m_axis_tlast});
      @(posedge aclk);
      idle++;
      if (in_fire) begin
        model_accept(stim_q.pop_front());
        holding = 1'b0;
        idle    = 0;
      end
      if (out_fire) begin
        if (model_q.size() == 0) begin
          $display("output word at t=%0t arrived when no word was expected", $time);
          other_errors++;
        end else begin
          check_word(model_q.pop_front(), act);
        end
        idle = 0;
      end
    end
    if (idle >= timeout_cycles) begin
      $display("timeout with %0d beats unsent and %0d words never seen",
               stim_q.size(), model_q.size());
      other_errors++;
      stim_q.delete();
      model_q.delete();
    end
    @(negedge aclk);
    // every expected word has left, nothing may follow
    check_flag("m_axis_tvalid", 1'b0, m_axis_tvalid);
    s_axis_tvalid = 1'b0;
  endtask

  initial begin
    int wait_cnt;
    lcg_state     = 32'h42e4;
    arst_n        = 1'b0;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tkeep  = '0;
    s_axis_tuser  = '0;
    s_axis_tlast  = 1'b0;
    m_axis_tready = 1'b0;
    pend_valid    = 1'b0;
    word_errors   = 0;
    flag_errors   = 0;
    other_errors  = 0;
    repeat (3) @(negedge aclk);
    arst_n = 1'b1;
    check_flag("m_axis_tvalid", 1'b0, m_axis_tvalid);
    // ready rises shortly after release
    wait_cnt = 0;
    while (s_axis_tready !== 1'b1 && wait_cnt < timeout_cycles) begin
      @(negedge aclk);
      wait_cnt++;
    end
    if (s_axis_tready !== 1'b1) begin
      $display("s_axis_tready never went high after reset");
      other_errors++;
    end
    // even lengths, full keep, no stalls
    build_packets(6, 0, 1'b0);
    run_traffic(0, 0);
    // odd lengths, last word half empty
    build_packets(6, 1, 1'b0);
    run_traffic(0, 0);
    // partial keep on last beats
    build_packets(10, 2, 1'b1);
    run_traffic(0, 0);
    // back-pressure and input gaps
    build_packets(60, 2, 1'b1);
    run_traffic(40, 30);
    $display("error counts: word %0d flag %0d other %0d", word_errors, flag_errors, other_errors);
    if (word_errors + flag_errors + other_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/axis_dw_pkg.sv
`default_nettype none

package axis_dw_pkg;

  // bytes carried by one narrow input beat
  localparam int s_bytes = 5;

  // narrow beats packed into one wide word
  // the datapath and fsm are written for exactly two
  localparam int lane_count = 2;

  // bytes in one wide output word
  localparam int m_bytes = s_bytes * lane_count;

  // sideband width, taken from the first beat of a word
  localparam int user_width = 8;

  // one narrow beat as seen on the slave side
  typedef struct packed {
    logic [s_bytes-1:0][7:0]  data;
    logic [s_bytes-1:0]       keep;
    logic [user_width-1:0]    user;
    logic                     last;
  } in_beat_t;

  // one assembled wide word, byte 0 in the lowest lane
  typedef struct packed {
    logic [m_bytes-1:0][7:0]  data;
    logic [m_bytes-1:0]       keep;
    logic [user_width-1:0]    user;
    logic                     last;
  } out_beat_t;

  // lane fill tracking
  // lane_lo waits for a low beat, lane_hi for a high beat, hold_full offers the word
  typedef enum logic [1:0] {
    lane_lo   = 2'd0,
    lane_hi   = 2'd1,
    hold_full = 2'd2
  } fill_state_t;

endpackage

`default_nettype wire

// File: hdl/axis_skid_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module axis_skid_buffer #(
  parameter type payload_t = logic
) (
  input  wire           aclk,
  input  wire           arst_n,

  // upstream side
  input  wire           in_valid,
  output logic          in_ready,
  input  wire payload_t in_data,

  // downstream side
  output logic          out_valid,
  input  wire           out_ready,
  output payload_t      out_data
);

  // side slot catches a beat that arrives while the output stalls
  payload_t side_data;
  logic     side_valid;

  logic     side_valid_nxt;
  logic     main_valid_nxt;
  logic     in_fire;
  logic     main_free;

  assign in_fire = in_valid & in_ready;

  // main slot empty or emptying this cycle
  assign main_free = ~out_valid | out_ready;

  always_comb begin
    main_valid_nxt = out_valid;
    side_valid_nxt = side_valid;
    if (main_free) begin
      // side entry is older, so it moves up first
      main_valid_nxt = side_valid | in_fire;
      side_valid_nxt = 1'b0;
    end else if (in_fire) begin
      // output stalled, park the new beat
      side_valid_nxt = 1'b1;
    end
  end

  // control state
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid  <= 1'b0;
      side_valid <= 1'b0;
      // ready rises one cycle after release
      in_ready   <= 1'b0;
    end else begin
      out_valid  <= main_valid_nxt;
      side_valid <= side_valid_nxt;
      // registered ready, low only while the side slot is occupied
      in_ready   <= ~side_valid_nxt;
    end
  end

  // payload slots
  always_ff @(posedge aclk) begin
    if (main_free) begin
      if (side_valid) begin
        out_data <= side_data;
      end else if (in_fire) begin
        out_data <= in_data;
      end
    end
    if (in_fire && !main_free) begin
      side_data <= in_data;
    end
  end

endmodule

`default_nettype wire

// File: hdl/axis_upsizer_top.sv
`timescale 1ns/1ps
`default_nettype none

module axis_upsizer_top
  import axis_dw_pkg::*;
(
  input  wire                         aclk,
  input  wire                         arst_n,

  // narrow slave stream
  input  wire                         s_axis_tvalid,
  output logic                        s_axis_tready,
  input  wire  [s_bytes-1:0][7:0]     s_axis_tdata,
  input  wire  [s_bytes-1:0]          s_axis_tkeep,
  input  wire  [user_width-1:0]       s_axis_tuser,
  input  wire                         s_axis_tlast,

  // wide master stream
  output logic                        m_axis_tvalid,
  input  wire                         m_axis_tready,
  output logic [m_bytes-1:0][7:0]     m_axis_tdata,
  output logic [m_bytes-1:0]          m_axis_tkeep,
  output logic [user_width-1:0]       m_axis_tuser,
  output logic                        m_axis_tlast
);

  // pins gathered into a beat
  in_beat_t  s_beat;

  // input skid to fsm and datapath
  in_beat_t  in_skid_beat;
  logic      in_skid_valid;
  logic      in_skid_ready;

  // fsm steering
  logic      load_lo;
  logic      load_hi;
  logic      clear_hi;

  // assembled word to the output skid
  out_beat_t asm_word;
  logic      word_valid;
  logic      word_ready;

  // output skid back to pins
  out_beat_t m_beat;

  assign s_beat = '{
    data: s_axis_tdata,
    keep: s_axis_tkeep,
    user: s_axis_tuser,
    last: s_axis_tlast
  };

  axis_skid_buffer #(
    .payload_t (in_beat_t)
  ) u_in_skid (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .in_valid  (s_axis_tvalid),
    .in_ready  (s_axis_tready),
    .in_data   (s_beat),
    .out_valid (in_skid_valid),
    .out_ready (in_skid_ready),
    .out_data  (in_skid_beat)
  );

  lane_fill_fsm u_fsm (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .beat_valid (in_skid_valid),
    .beat_ready (in_skid_ready),
    .beat_last  (in_skid_beat.last),
    .load_lo    (load_lo),
    .load_hi    (load_hi),
    .clear_hi   (clear_hi),
    .word_valid (word_valid),
    .word_ready (word_ready)
  );

  lane_pack_datapath u_datapath (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .beat     (in_skid_beat),
    .load_lo  (load_lo),
    .load_hi  (load_hi),
    .clear_hi (clear_hi),
    .word     (asm_word)
  );

  axis_skid_buffer #(
    .payload_t (out_beat_t)
  ) u_out_skid (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .in_valid  (word_valid),
    .in_ready  (word_ready),
    .in_data   (asm_word),
    .out_valid (m_axis_tvalid),
    .out_ready (m_axis_tready),
    .out_data  (m_beat)
  );

  // word back onto pins
  assign m_axis_tdata = m_beat.data;
  assign m_axis_tkeep = m_beat.keep;
  assign m_axis_tuser = m_beat.user;
  assign m_axis_tlast = m_beat.last;

endmodule

`default_nettype wire

// File: hdl/lane_fill_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module lane_fill_fsm
  import axis_dw_pkg::*;
(
  input  wire  aclk,
  input  wire  arst_n,

  // narrow beat handshake from the input skid
  input  wire  beat_valid,
  output logic beat_ready,
  input  wire  beat_last,

  // datapath steering
  output logic load_lo,
  output logic load_hi,
  output logic clear_hi,

  // wide word handshake toward the output skid
  output logic word_valid,
  input  wire  word_ready
);

  fill_state_t state;
  fill_state_t state_nxt;

  logic beat_fire;
  logic word_fire;
  logic lo_slot;

  // word is complete only in hold_full
  assign word_valid = (state == hold_full);
  assign word_fire  = word_valid & word_ready;

  // beats are taken in both fill states
  // in hold_full only when the word leaves this cycle
  always_comb begin
    unique case (state)
      lane_lo:   beat_ready = 1'b1;
      lane_hi:   beat_ready = 1'b1;
      hold_full: beat_ready = word_ready;
      default:   beat_ready = 1'b0;
    endcase
  end

  assign beat_fire = beat_valid & beat_ready;

  // a beat accepted now lands in the lower lanes
  assign lo_slot = (state == lane_lo) | (state == hold_full);

  assign load_lo  = beat_fire & lo_slot;
  assign load_hi  = beat_fire & (state == lane_hi);
  // early last, upper half of the word stays empty
  assign clear_hi = load_lo & beat_last;

  always_comb begin
    state_nxt = state;
    unique case (state)
      lane_lo: begin
        if (beat_fire) begin
          state_nxt = beat_last ? hold_full : lane_hi;
        end
      end
      lane_hi: begin
        // second beat always closes the word
        if (beat_fire) begin
          state_nxt = hold_full;
        end
      end
      hold_full: begin
        if (word_fire) begin
          // back-to-back start of the next word
          if (beat_fire) begin
            state_nxt = beat_last ? hold_full : lane_hi;
          end else begin
            state_nxt = lane_lo;
          end
        end
      end
      default: begin
        state_nxt = lane_lo;
      end
    endcase
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      state <= lane_lo;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

`default_nettype wire

// File: hdl/lane_pack_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module lane_pack_datapath
  import axis_dw_pkg::*;
(
  input  wire           aclk,
  input  wire           arst_n,

  // beat from the input skid, already qualified by the fsm loads
  input  wire in_beat_t beat,

  // lane steering from the fsm
  input  wire           load_lo,
  input  wire           load_hi,
  input  wire           clear_hi,

  // assembled word toward the output skid
  output out_beat_t     word
);

  // lower lanes, bytes 0 to s_bytes-1
  logic [s_bytes-1:0][7:0] lo_data;
  logic [s_bytes-1:0]      lo_keep;

  // upper lanes, bytes s_bytes to m_bytes-1
  logic [s_bytes-1:0][7:0] hi_data;
  logic [s_bytes-1:0]      hi_keep;

  // word sideband
  logic [user_width-1:0]   user_q;
  logic                    last_q;

  // keep and last qualify the word, so they start cleared
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      lo_keep <= '0;
      hi_keep <= '0;
      last_q  <= 1'b0;
    end else begin
      if (load_lo) begin
        lo_keep <= beat.keep;
        // last of the low beat, overwritten if a high beat follows
        last_q  <= beat.last;
      end
      if (load_hi) begin
        hi_keep <= beat.keep;
        last_q  <= beat.last;
      end else if (clear_hi) begin
        // word closed after one beat
        hi_keep <= '0;
      end
    end
  end

  // byte lanes and user
  always_ff @(posedge aclk) begin
    if (load_lo) begin
      lo_data <= beat.data;
      // user of the first beat names the word
      user_q  <= beat.user;
    end
    if (load_hi) begin
      hi_data <= beat.data;
    end else if (clear_hi) begin
      // no stale bytes from the previous word
      hi_data <= '0;
    end
  end

  // join lanes, lower first
  always_comb begin
    word      = '0;
    word.data = {hi_data, lo_data};
    word.keep = {hi_keep, lo_keep};
    word.user = user_q;
    word.last = last_q;
  end

endmodule

`default_nettype wire
